// ==== pc_unit.f ====
rtl/pc_unit_pkg.sv
rtl/branch_cmp.sv
rtl/regfile.sv
rtl/trap_csr.sv
rtl/pc_sequencer.sv
rtl/pc_unit_top.sv
verif/pc_unit_assert.sv
verif/tb_pc_unit.sv

// ==== rtl/branch_cmp.sv ====
`timescale 1ns/10ps

module branch_cmp (
   input  pc_unit_pkg::cmp_op_e cmp_op,
   input  pc_unit_pkg::xlen_t   a,
   input  pc_unit_pkg::xlen_t   b,
   output logic                 taken
);

   logic eq;
   logic lt_s;
   logic lt_u;

   // shared compare terms, the six conditions reuse them
   assign eq   = (a == b);
   assign lt_s = ($signed(a) < $signed(b));
   assign lt_u = (a < b);

   // taken is high when the branch goes to pc + imm
   always_comb begin
      case (cmp_op)
         pc_unit_pkg::cmp_eq: begin
            taken = eq;
         end
         pc_unit_pkg::cmp_ne: begin
            taken = !eq;
         end
         pc_unit_pkg::cmp_lt: begin
            taken = lt_s;
         end
         pc_unit_pkg::cmp_ge: begin
            taken = !lt_s;     // signed greater or equal
         end
         pc_unit_pkg::cmp_ltu: begin
            taken = lt_u;
         end
         pc_unit_pkg::cmp_geu: begin
            taken = !lt_u;
         end
         default: begin
            taken = 1'b0;      // unused funct3 codes never branch
         end
      endcase
   end

endmodule

// ==== rtl/pc_sequencer.sv ====
`timescale 1ns/10ps

module pc_sequencer (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 instr_valid,
   input  pc_unit_pkg::pc_ctrl_t ctrl,
   input  logic                 taken,
   input  pc_unit_pkg::xlen_t   rs1_data,
   input  pc_unit_pkg::xlen_t   mtvec,
   input  pc_unit_pkg::xlen_t   mepc,
   output pc_unit_pkg::xlen_t   pc,
   output logic                 busy,
   output logic                 ecall_strobe,
   output logic                 mret_strobe
);

   pc_unit_pkg::seq_state_e state_q;
   pc_unit_pkg::seq_state_e state_d;
   pc_unit_pkg::xlen_t      pc_q;
   pc_unit_pkg::xlen_t      pc_d;
   pc_unit_pkg::xlen_t      jalr_imm_q;   // offset of the deferred jalr
   pc_unit_pkg::xlen_t      pc_seq;
   logic                    accept;
   logic                    defer;

   // jalr target, bit 0 always cleared
   function automatic pc_unit_pkg::xlen_t jalr_target(
      input pc_unit_pkg::xlen_t base,
      input pc_unit_pkg::xlen_t off
   );
      pc_unit_pkg::xlen_t sum;
      sum = base + off;
      return {sum[pc_unit_pkg::xlen-1:1], 1'b0};
   endfunction

   assign busy   = (state_q == pc_unit_pkg::st_jalr_wait);
   assign accept = instr_valid && !busy;    // strobes dropped while busy
   assign pc_seq = pc_q + pc_unit_pkg::pc_step;
   assign defer  = accept && (ctrl.kind == pc_unit_pkg::kind_jalr) && ctrl.load_pending;

   always_comb begin
      pc_d         = pc_q;        // hold unless something moves it
      state_d      = state_q;
      ecall_strobe = 1'b0;
      mret_strobe  = 1'b0;
      if (busy) begin
         // rs1 now carries the value written at the strobe edge
         pc_d    = jalr_target(rs1_data, jalr_imm_q);
         state_d = pc_unit_pkg::st_run;
      end else if (accept) begin
         case (ctrl.kind)
            pc_unit_pkg::kind_branch: begin
               pc_d = taken ? (pc_q + ctrl.imm) : pc_seq;
            end
            pc_unit_pkg::kind_jal: begin
               pc_d = pc_q + ctrl.imm;
            end
            pc_unit_pkg::kind_jalr: begin
               if (ctrl.load_pending) begin
                  state_d = pc_unit_pkg::st_jalr_wait;   // pc holds for a cycle
               end else begin
                  pc_d = jalr_target(rs1_data, ctrl.imm);
               end
            end
            pc_unit_pkg::kind_ecall: begin
               pc_d         = mtvec;
               ecall_strobe = 1'b1;   // trap_csr latches pc_q as mepc
            end
            pc_unit_pkg::kind_ebreak: begin
               pc_d = pc_unit_pkg::reset_vector;
            end
            pc_unit_pkg::kind_mret: begin
               pc_d        = mepc;    // back to the trapping instruction
               mret_strobe = 1'b1;
            end
            default: begin
               pc_d = pc_seq;         // kind_seq
            end
         endcase
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pc_q    <= pc_unit_pkg::reset_vector;
         state_q <= pc_unit_pkg::st_run;
      end else begin
         pc_q    <= pc_d;
         state_q <= state_d;
      end
   end

   // offset kept only for the wait cycle
   always_ff @(posedge clk) begin
      if (defer) begin
         jalr_imm_q <= ctrl.imm;
      end
   end

   assign pc = pc_q;

endmodule

// ==== rtl/pc_unit_pkg.sv ====
package pc_unit_pkg;

   // datapath width, rv64
   localparam int unsigned xlen = 64;
   localparam int unsigned reg_idx_w = 5;
   localparam int unsigned nregs = 32;         // x0..x31

   typedef logic [xlen-1:0] xlen_t;           // address or register data
   typedef logic [reg_idx_w-1:0] reg_idx_t;   // register number

   // pc after reset, also where ebreak lands
   localparam xlen_t reset_vector = 64'h0000_0000_8000_0000;
   localparam xlen_t pc_step = 64'd4;          // sequential increment
   localparam xlen_t cause_ecall_m = 64'd11;   // ecall from m-mode

   // kind of the instruction carried by one strobe
   typedef enum logic [2:0] {
      kind_seq    = 3'd0,
      kind_branch = 3'd1,
      kind_jal    = 3'd2,
      kind_jalr   = 3'd3,
      kind_ecall  = 3'd4,
      kind_ebreak = 3'd5,
      kind_mret   = 3'd6
   } instr_kind_e;

   // follows the funct3 field of the branch opcodes
   typedef enum logic [2:0] {
      cmp_eq  = 3'b000,
      cmp_ne  = 3'b001,
      cmp_lt  = 3'b100,
      cmp_ge  = 3'b101,
      cmp_ltu = 3'b110,
      cmp_geu = 3'b111
   } cmp_op_e;

   typedef enum logic {
      st_run       = 1'b0,
      st_jalr_wait = 1'b1   // jalr base still waiting on a load
   } seq_state_e;

   // decoded control for one instruction
   typedef struct packed {
      instr_kind_e kind;
      cmp_op_e     cmp_op;
      reg_idx_t    rs1;
      reg_idx_t    rs2;
      xlen_t       imm;          // sign-extended already
      logic        load_pending; // rs1 is the target of a load in flight
   } pc_ctrl_t;

   // register file write
   typedef struct packed {
      logic     valid;
      reg_idx_t rd;
      xlen_t    data;
   } wb_t;

endpackage

// ==== rtl/pc_unit_top.sv ====
`timescale 1ns/10ps

module pc_unit_top (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  instr_valid,
   input  pc_unit_pkg::pc_ctrl_t ctrl,
   input  pc_unit_pkg::wb_t      wb,
   input  logic                  csr_wr_valid,
   input  pc_unit_pkg::xlen_t    csr_wr_data,
   output pc_unit_pkg::xlen_t    pc,
   output logic                  busy
);

   pc_unit_pkg::xlen_t rs1_data;
   pc_unit_pkg::xlen_t rs2_data;
   pc_unit_pkg::xlen_t mtvec;
   pc_unit_pkg::xlen_t mepc;
   logic               taken;
   logic               ecall_strobe;

   // ctrl.rs1 must stay put through a deferred jalr
   regfile i_regfile (
      .clk      (clk),
      .rst_n    (rst_n),
      .wb       (wb),
      .rs1      (ctrl.rs1),
      .rs2      (ctrl.rs2),
      .rs1_data (rs1_data),
      .rs2_data (rs2_data)
   );

   branch_cmp i_branch_cmp (
      .cmp_op (ctrl.cmp_op),
      .a      (rs1_data),
      .b      (rs2_data),
      .taken  (taken)
   );

   trap_csr i_trap_csr (
      .clk          (clk),
      .rst_n        (rst_n),
      .csr_wr_valid (csr_wr_valid),
      .csr_wr_data  (csr_wr_data),
      .ecall_strobe (ecall_strobe),
      .epc          (pc),
      .mtvec        (mtvec),
      .mepc         (mepc)
   );

   // mret strobe has no consumer in the csr block yet
   pc_sequencer i_pc_sequencer (
      .clk          (clk),
      .rst_n        (rst_n),
      .instr_valid  (instr_valid),
      .ctrl         (ctrl),
      .taken        (taken),
      .rs1_data     (rs1_data),
      .mtvec        (mtvec),
      .mepc         (mepc),
      .pc           (pc),
      .busy         (busy),
      .ecall_strobe (ecall_strobe),
      .mret_strobe  ()
   );

endmodule

// ==== rtl/regfile.sv ====
`timescale 1ns/10ps

module regfile (
   input  logic                 clk,
   input  logic                 rst_n,
   input  pc_unit_pkg::wb_t     wb,
   input  pc_unit_pkg::reg_idx_t rs1,
   input  pc_unit_pkg::reg_idx_t rs2,
   output pc_unit_pkg::xlen_t   rs1_data,
   output pc_unit_pkg::xlen_t   rs2_data
);

   // x1..x31, x0 has no storage
   pc_unit_pkg::xlen_t regs [1:pc_unit_pkg::nregs-1];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 1; i < pc_unit_pkg::nregs; i++) begin
            regs[i] <= '0;
         end
      end else if (wb.valid && (wb.rd != '0)) begin
         regs[wb.rd] <= wb.data;   // writes to x0 dropped
      end
   end

   // combinational reads, old value seen during the write edge
   assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
   assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== rtl/trap_csr.sv ====
`timescale 1ns/10ps

module trap_csr (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               csr_wr_valid,
   input  pc_unit_pkg::xlen_t csr_wr_data,
   input  logic               ecall_strobe,
   input  pc_unit_pkg::xlen_t epc,
   output pc_unit_pkg::xlen_t mtvec,
   output pc_unit_pkg::xlen_t mepc
);

   pc_unit_pkg::xlen_t mtvec_q;
   pc_unit_pkg::xlen_t mepc_q;
   pc_unit_pkg::xlen_t mcause_q;   // no read path yet

   // trap vector base, direct mode only
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         mtvec_q <= '0;
      end else if (csr_wr_valid) begin
         mtvec_q <= {csr_wr_data[pc_unit_pkg::xlen-1:2], 2'b00};  // mode bits forced 0
      end
   end

   // exception pc and cause, captured on ecall
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         mepc_q   <= '0;
         mcause_q <= '0;
      end else if (ecall_strobe) begin
         mepc_q   <= epc;                          // pc of the ecall itself
         mcause_q <= pc_unit_pkg::cause_ecall_m;
      end
   end

   assign mtvec = mtvec_q;
   assign mepc  = mepc_q;

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the pc unit testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f pc_unit.f --top-module tb_pc_unit \
   -o sim_pc_unit > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/sim_pc_unit > sim.log 2>&1 || echo "simulator returned an error status" >> sim.log
cat sim.log
grep -q "SOME TESTS FAILED" sim.log && { echo "result: fail"; exit 1; } || \
   grep -q "ALL TESTS PASSED" sim.log && echo "result: pass" && exit 0 || \
   { echo "result: fail, no pass line in sim.log"; exit 1; }

// ==== verif/pc_unit_assert.sv ====
`timescale 1ns/10ps

module pc_unit_assert (
   input logic                     clk,
   input logic                     rst_n,
   input logic                     busy,
   input logic                     accept,
   input pc_unit_pkg::instr_kind_e kind,
   input logic                     ecall_strobe,
   input logic                     mret_strobe,
   input pc_unit_pkg::xlen_t       pc
);

   logic jalr_seen;   // once a jalr loads, bit 1 may be set

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         jalr_seen <= 1'b0;
      end else if (accept && kind == pc_unit_pkg::kind_jalr) begin
         jalr_seen <= 1'b1;
      end
   end

   busy_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
      busy |=> !busy) else $error("busy held longer than one cycle");

   // the wait cycle must win over any new instruction
   busy_no_accept: assert property (@(posedge clk) disable iff (!rst_n)
      busy |-> !ecall_strobe && !mret_strobe) else $error("strobe accepted while busy");

   trap_strobes_excl: assert property (@(posedge clk) disable iff (!rst_n)
      !(ecall_strobe && mret_strobe)) else $error("ecall and mret strobes together");

   pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
      (pc[0] == 1'b0) && (jalr_seen || pc[1] == 1'b0)) else $error("pc misaligned");

endmodule

// ==== verif/tb_pc_unit.sv ====
`timescale 1ns/10ps

module tb_pc_unit;

   typedef struct packed {
      int                 due;       // negedge count when the check runs
      logic               is_busy;   // check busy instead of pc
      pc_unit_pkg::xlen_t expv;
      int                 test;
   } exp_entry_t;

   logic                  clk;
   logic                  rst_n;
   logic                  instr_valid;
   pc_unit_pkg::pc_ctrl_t ctrl;
   pc_unit_pkg::wb_t      wb;
   logic                  csr_wr_valid;
   pc_unit_pkg::xlen_t    csr_wr_data;
   pc_unit_pkg::xlen_t    pc;
   logic                  busy;

   // reference state
   pc_unit_pkg::xlen_t model_pc;
   pc_unit_pkg::xlen_t model_regs [0:31];
   pc_unit_pkg::xlen_t model_mtvec;
   pc_unit_pkg::xlen_t model_mepc;

   exp_entry_t exp_q[$];
   exp_entry_t cur;
   int         neg_cnt;
   int         n_checks;
   int         n_errors;
   int         n_strobes;
   int         test_err [0:5];
   string      test_names [0:5];

   pc_unit_top i_dut (
      .clk          (clk),
      .rst_n        (rst_n),
      .instr_valid  (instr_valid),
      .ctrl         (ctrl),
      .wb           (wb),
      .csr_wr_valid (csr_wr_valid),
      .csr_wr_data  (csr_wr_data),
      .pc           (pc),
      .busy         (busy)
   );

   bind pc_sequencer pc_unit_assert i_assert (
      .clk          (clk),
      .rst_n        (rst_n),
      .busy         (busy),
      .accept       (accept),
      .kind         (ctrl.kind),
      .ecall_strobe (ecall_strobe),
      .mret_strobe  (mret_strobe),
      .pc           (pc)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   function automatic pc_unit_pkg::xlen_t reg_val(input pc_unit_pkg::reg_idx_t idx);
      return (idx == 0) ? '0 : model_regs[idx];
   endfunction

   // expected next pc, straight from the instruction rules
   function automatic pc_unit_pkg::xlen_t next_pc(
      input pc_unit_pkg::pc_ctrl_t c,
      input pc_unit_pkg::xlen_t    cur_pc,
      input pc_unit_pkg::xlen_t    a,
      input pc_unit_pkg::xlen_t    b,
      input pc_unit_pkg::xlen_t    mtvec,
      input pc_unit_pkg::xlen_t    mepc
   );
      logic               cond;
      pc_unit_pkg::xlen_t t;
      cond = 1'b0;
      case (c.cmp_op)
         pc_unit_pkg::cmp_eq:  cond = (a == b);
         pc_unit_pkg::cmp_ne:  cond = (a != b);
         pc_unit_pkg::cmp_lt:  cond = ($signed(a) < $signed(b));
         pc_unit_pkg::cmp_ge:  cond = ($signed(a) >= $signed(b));
         pc_unit_pkg::cmp_ltu: cond = (a < b);
         pc_unit_pkg::cmp_geu: cond = (a >= b);
         default:              cond = 1'b0;
      endcase
      case (c.kind)
         pc_unit_pkg::kind_branch: return cond ? cur_pc + c.imm : cur_pc + 64'd4;
         pc_unit_pkg::kind_jal:    return cur_pc + c.imm;
         pc_unit_pkg::kind_jalr: begin
            t = a + c.imm;
            t[0] = 1'b0;
            return t;
         end
         pc_unit_pkg::kind_ecall:  return mtvec;
         pc_unit_pkg::kind_ebreak: return 64'h0000_0000_8000_0000;
         pc_unit_pkg::kind_mret:   return mepc;
         default:                  return cur_pc + 64'd4;
      endcase
   endfunction

   function automatic pc_unit_pkg::pc_ctrl_t mk_ctrl(
      input pc_unit_pkg::instr_kind_e k,
      input pc_unit_pkg::cmp_op_e     op,
      input pc_unit_pkg::reg_idx_t    rs1,
      input pc_unit_pkg::reg_idx_t    rs2,
      input pc_unit_pkg::xlen_t       imm,
      input logic                     lp
   );
      pc_unit_pkg::pc_ctrl_t c;
      c.kind         = k;
      c.cmp_op       = op;
      c.rs1          = rs1;
      c.rs2          = rs2;
      c.imm          = imm;
      c.load_pending = lp;
      return c;
   endfunction

   function automatic pc_unit_pkg::wb_t mk_wb(
      input logic                  v,
      input pc_unit_pkg::reg_idx_t rd,
      input pc_unit_pkg::xlen_t    data
   );
      pc_unit_pkg::wb_t w;
      w.valid = v;
      w.rd    = rd;
      w.data  = data;
      return w;
   endfunction

   // aligned data keeps every jump target word aligned
   function automatic pc_unit_pkg::xlen_t rand_data();
      pc_unit_pkg::xlen_t d;
      d = {$urandom, $urandom};
      d[1:0] = 2'b00;
      return d;
   endfunction

   function automatic pc_unit_pkg::xlen_t rand_imm();
      logic [11:0] r;
      r = 12'($urandom);
      r[1:0] = 2'b00;
      return {{52{r[11]}}, r};
   endfunction

   task automatic check_val(input string what, input pc_unit_pkg::xlen_t expv,
                            input pc_unit_pkg::xlen_t act, input int test);
      n_checks++;
      if (expv !== act) begin
         n_errors++;
         test_err[test]++;
         $display("FAILED %s %s: expected %h, actual %h",
                  test_names[test], what, expv, act);
      end
   endtask

   // one strobe, model updated in the same step
   task automatic issue(input pc_unit_pkg::pc_ctrl_t c, input pc_unit_pkg::wb_t w,
                        input int test);
      pc_unit_pkg::xlen_t a;
      pc_unit_pkg::xlen_t b;
      pc_unit_pkg::xlen_t expv;
      exp_entry_t         e;
      logic               deferred;
      @(posedge clk);
      deferred = (c.kind == pc_unit_pkg::kind_jalr) && c.load_pending;
      a = reg_val(c.rs1);
      b = reg_val(c.rs2);
      if (w.valid && w.rd != 0) begin
         model_regs[w.rd] = w.data;
      end
      if (deferred) begin
         a = reg_val(c.rs1);   // deferred target sees the new write
      end
      expv = next_pc(c, model_pc, a, b, model_mtvec, model_mepc);
      if (c.kind == pc_unit_pkg::kind_ecall) begin
         model_mepc = model_pc;
      end
      model_pc = expv;
      if (deferred) begin
         e = '{due: neg_cnt + 2, is_busy: 1'b1, expv: 64'd1, test: test};
         exp_q.push_back(e);
         e = '{due: neg_cnt + 3, is_busy: 1'b0, expv: expv, test: test};
      end else begin
         e = '{due: neg_cnt + 2, is_busy: 1'b0, expv: expv, test: test};
      end
      exp_q.push_back(e);
      instr_valid <= 1'b1;
      ctrl        <= c;
      wb          <= w;
      n_strobes++;
      @(posedge clk);
      instr_valid <= 1'b0;   // ctrl stays put through a busy cycle
      wb          <= '0;
   endtask

   task automatic write_reg(input pc_unit_pkg::reg_idx_t rd, input pc_unit_pkg::xlen_t d);
      @(posedge clk);
      wb <= mk_wb(1'b1, rd, d);
      if (rd != 0) begin
         model_regs[rd] = d;
      end
      @(posedge clk);
      wb <= '0;
   endtask

   task automatic write_mtvec(input pc_unit_pkg::xlen_t d);
      @(posedge clk);
      csr_wr_valid <= 1'b1;
      csr_wr_data  <= d;
      model_mtvec = {d[63:2], 2'b00};
      @(posedge clk);
      csr_wr_valid <= 1'b0;
   endtask

   task automatic drain();
      while (exp_q.size() != 0) begin
         @(negedge clk);
      end
   endtask

   task automatic report_test(input int test);
      drain();
      $display("test %0d %s: %0d mismatches", test + 1, test_names[test], test_err[test]);
   endtask

   // comparison process, samples at the falling edge
   always @(negedge clk) begin
      neg_cnt++;
      while (exp_q.size() != 0 && exp_q[0].due == neg_cnt) begin
         cur = exp_q.pop_front();
         if (cur.is_busy) begin
            check_val("busy", cur.expv, {63'd0, busy}, cur.test);
         end else begin
            check_val("pc", cur.expv, pc, cur.test);
         end
      end
   end

   // watchdog, 346 strobes budgeted at 4 cycles each
   initial begin
      int max_cycles;
      max_cycles = 16 + 346 * 4 + 200;
      repeat (max_cycles) @(posedge clk);
      $display("timeout: run did not finish within %0d cycles", max_cycles);
      $display("SOME TESTS FAILED");
      $finish;
   end

   initial begin
      pc_unit_pkg::reg_idx_t r1;
      pc_unit_pkg::reg_idx_t r2;
      pc_unit_pkg::xlen_t    d;
      pc_unit_pkg::xlen_t    ecall_pc;
      pc_unit_pkg::pc_ctrl_t c;
      pc_unit_pkg::wb_t      w;
      int                    k;
      void'($urandom(93880));
      test_names = '{"reset_seq", "branches", "jal_jalr", "deferred_jalr", "traps",
                     "random_mix"};
      rst_n        = 1'b0;
      instr_valid  = 1'b0;
      ctrl         = '0;
      wb           = '0;
      csr_wr_valid = 1'b0;
      csr_wr_data  = '0;
      neg_cnt      = 0;
      n_checks     = 0;
      n_errors     = 0;
      n_strobes    = 0;
      for (int i = 0; i < 6; i++) test_err[i] = 0;
      for (int i = 0; i < 32; i++) model_regs[i] = '0;
      model_pc    = 64'h0000_0000_8000_0000;
      model_mtvec = '0;
      model_mepc  = '0;
      repeat (16) @(posedge clk);
      rst_n <= 1'b1;

      // 1: reset value then plain increments
      @(negedge clk);
      check_val("pc after reset", 64'h0000_0000_8000_0000, pc, 0);
      for (int i = 0; i < 10; i++) begin
         issue(mk_ctrl(pc_unit_pkg::kind_seq, pc_unit_pkg::cmp_eq, 0, 0, 0, 0), '0, 0);
      end
      report_test(0);

      // 2: every condition, equal and sign-flipped operands included
      for (int op = 0; op < 6; op++) begin
         for (int j = 0; j < 4; j++) begin
            d = rand_data();
            write_reg(5'd3, d);
            case (j)
               0: write_reg(5'd4, d);
               1: write_reg(5'd4, d ^ 64'h8000_0000_0000_0000);  // sign bit only
               default: write_reg(5'd4, rand_data());
            endcase
            c = mk_ctrl(pc_unit_pkg::kind_branch,
                        pc_unit_pkg::cmp_op_e'(op < 2 ? op : op + 2), 3, 4, rand_imm(), 0);
            issue(c, '0, 1);
         end
      end
      report_test(1);

      // 3: jal and jalr, odd offset to hit the bit 0 clear
      write_reg(5'd7, rand_data());
      issue(mk_ctrl(pc_unit_pkg::kind_jal, pc_unit_pkg::cmp_eq, 0, 0, rand_imm(), 0), '0, 2);
      issue(mk_ctrl(pc_unit_pkg::kind_jalr, pc_unit_pkg::cmp_eq, 7, 0, 64'd9, 0), '0, 2);
      issue(mk_ctrl(pc_unit_pkg::kind_jalr, pc_unit_pkg::cmp_eq, 7, 0, rand_imm(), 0), '0, 2);
      issue(mk_ctrl(pc_unit_pkg::kind_jalr, pc_unit_pkg::cmp_eq, 0, 0, 64'h1004, 0), '0, 2);
      issue(mk_ctrl(pc_unit_pkg::kind_jal, pc_unit_pkg::cmp_eq, 0, 0, -64'sd16, 0), '0, 2);
      report_test(2);

      // 4: load result lands at the strobe edge
      write_reg(5'd5, rand_data());
      c = mk_ctrl(pc_unit_pkg::kind_jalr, pc_unit_pkg::cmp_eq, 5, 0, 64'd8, 1);
      issue(c, mk_wb(1'b1, 5'd5, rand_data()), 3);
      issue(mk_ctrl(pc_unit_pkg::kind_seq, pc_unit_pkg::cmp_eq, 0, 0, 0, 0), '0, 3);
      report_test(3);

      // 5: ecall, mret back, ebreak
      write_mtvec(64'h0000_0000_0000_4003);
      issue(mk_ctrl(pc_unit_pkg::kind_seq, pc_unit_pkg::cmp_eq, 0, 0, 0, 0), '0, 4);
      ecall_pc = model_pc;
      issue(mk_ctrl(pc_unit_pkg::kind_ecall, pc_unit_pkg::cmp_eq, 0, 0, 0, 0), '0, 4);
      issue(mk_ctrl(pc_unit_pkg::kind_seq, pc_unit_pkg::cmp_eq, 0, 0, 0, 0), '0, 4);
      issue(mk_ctrl(pc_unit_pkg::kind_mret, pc_unit_pkg::cmp_eq, 0, 0, 0, 0), '0, 4);
      drain();
      check_val("mret return", ecall_pc, pc, 4);
      issue(mk_ctrl(pc_unit_pkg::kind_ebreak, pc_unit_pkg::cmp_eq, 0, 0, 0, 0), '0, 4);
      report_test(4);

      // 6: random kinds with interleaved writes
      for (int i = 0; i < 300; i++) begin
         k  = $urandom_range(0, 6);
         r1 = 5'($urandom);
         r2 = 5'($urandom);
         c  = mk_ctrl(pc_unit_pkg::instr_kind_e'(k),
                      pc_unit_pkg::cmp_op_e'($urandom_range(0, 5) < 2 ? $urandom_range(0, 1)
                                             : $urandom_range(4, 7)),
                      r1, r2, rand_imm(), 1'b0);
         w = '0;
         if (c.kind == pc_unit_pkg::kind_jalr && $urandom_range(0, 1) == 1) begin
            c.load_pending = 1'b1;
            w = mk_wb(1'b1, r1, rand_data());
         end else if ($urandom_range(0, 9) < 3) begin
            w = mk_wb(1'b1, 5'($urandom), rand_data());
         end
         issue(c, w, 5);
      end
      report_test(5);

      $display("strobes: %0d, checks: %0d, mismatches: %0d", n_strobes, n_checks, n_errors);
      if (n_errors == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule
